// ==== hw/bus_map_pkg.sv ====
// Data bus memory map
package bus_map_pkg;

    // ------------------------------------------------------------
    // bus geometry
    // ------------------------------------------------------------

    // the address covers 1024 words, of which 776 are mapped
    localparam int addr_width = 10;
    localparam int data_width = 16;

    // ------------------------------------------------------------
    // memory map
    // ------------------------------------------------------------

    // data RAM fills the bottom of the map, 768 words, so its range is
    // deliberately not a power of two
    localparam int ram_base  = 0;
    localparam int ram_bound = 767;

    // eight I/O registers sit right above the RAM
    localparam int io_base  = 768;
    localparam int io_bound = 775;

    // the first six I/O words are outputs, the last two read external inputs
    localparam int io_out_count = 6;
    localparam int io_in_count  = 2;

    // derived sizes used by the targets to index their own storage
    localparam int ram_depth     = ram_bound - ram_base + 1;
    localparam int ram_idx_width = $clog2(ram_depth);
    localparam int io_idx_width  = $clog2(io_out_count + io_in_count);

    // ------------------------------------------------------------
    // bus request and response
    // ------------------------------------------------------------

    // one access per cycle, wren and rden must never be high together
    typedef struct packed {
        logic                  wren;
        logic                  rden;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
    } bus_req_t;

    // response appears exactly one cycle after the access
    typedef struct packed {
        logic                  valid;
        logic                  error;
        logic [data_width-1:0] rdata;
    } bus_rsp_t;

endpackage

// ==== hw/address_range_decoder_static.sv ====
// Address range decoder
module address_range_decoder_static
    import bus_map_pkg::*;
#(
    parameter int addr_base  = 0,
    parameter int addr_bound = 0
) (
    input  logic                  enable,
    input  logic [addr_width-1:0] addr,
    output logic                  hit
);

    // number of addresses covered, bound is inclusive
    localparam int addr_count = addr_bound - addr_base + 1;

    // ------------------------------------------------------------
    // per address compare
    // ------------------------------------------------------------

    // one match bit per address in the range
    logic [addr_count-1:0] per_addr_match;

    // compare the bus address against every address in the range
    // any address bit that sweeps its full binary range inside the range
    // turns into a don't care once the matches are ORed, so synthesis
    // collapses this into the smallest decoder for aligned and unaligned
    // ranges alike
    always_comb begin
        per_addr_match = '0;
        for (int i = addr_base; i <= addr_bound; i++) begin
            per_addr_match[i - addr_base] = (addr == addr_width'(i));
        end
    end

    // ------------------------------------------------------------
    // hit
    // ------------------------------------------------------------

    // the range is claimed only while an access is actually on the bus
    assign hit = (|per_addr_match) & enable;

endmodule

// ==== hw/data_ram.sv ====
// Data RAM
module data_ram
    import bus_map_pkg::*;
(
    input  logic                  clock,
    input  logic                  sel,
    input  bus_req_t              req,
    output logic [data_width-1:0] rdata
);

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------

    // the RAM holds exactly the words of its mapped range
    logic [data_width-1:0] mem [0:ram_depth-1];

    // offset of the access inside the RAM range
    logic [ram_idx_width-1:0] ram_offset;

    // the RAM removes its own base, the decoder only says whether it is hit
    assign ram_offset = ram_idx_width'(req.addr - addr_width'(ram_base));

    // ------------------------------------------------------------
    // write port
    // ------------------------------------------------------------

    // a write lands at the edge that closes the access cycle, so a read in
    // the next cycle already returns the new word
    always_ff @(posedge clock) begin
        if (sel && req.wren) begin
            mem[ram_offset] <= req.wdata;
        end
    end

    // ------------------------------------------------------------
    // read port
    // ------------------------------------------------------------

    // read data is registered on the access edge and then held until the
    // next read of the RAM
    always_ff @(posedge clock) begin
        if (sel && req.rden) begin
            rdata <= mem[ram_offset];
        end
    end

    // the contents carry no reset, software must initialise what it reads
    // before it relies on the value

endmodule

// ==== hw/io_register_file.sv ====
// I/O register block
module io_register_file
    import bus_map_pkg::*;
(
    input  logic                                      clock,
    input  logic                                      rst_n,
    input  logic                                      sel,
    input  bus_req_t                                  req,
    input  logic [io_in_count-1:0][data_width-1:0]    io_in,
    output logic [io_out_count-1:0][data_width-1:0]   io_out,
    output logic [data_width-1:0]                     rdata
);

    // ------------------------------------------------------------
    // local offset
    // ------------------------------------------------------------

    // word offset inside the I/O block, 0 to 7
    logic [io_idx_width-1:0] io_offset;

    // true when the offset points at one of the writable outputs
    logic out_slot;

    // word that a read at the current offset would return
    logic [data_width-1:0] read_word;

    assign io_offset = io_idx_width'(req.addr - addr_width'(io_base));
    assign out_slot  = (io_offset < io_idx_width'(io_out_count));

    // ------------------------------------------------------------
    // output registers
    // ------------------------------------------------------------

    // offsets 0 to 5 are plain registers driven straight onto io_out
    // writes to the two input slots fall through without effect
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            io_out <= '0;
        end else if (sel && req.wren && out_slot) begin
            io_out[io_offset] <= req.wdata;
        end
    end

    // ------------------------------------------------------------
    // read path
    // ------------------------------------------------------------

    // outputs read back their own value, the upper two slots sample io_in
    always_comb begin
        if (out_slot) begin
            read_word = io_out[io_offset];
        end else begin
            read_word = io_in[io_offset - io_idx_width'(io_out_count)];
        end
    end

    // the read word is captured on the access edge, like the RAM, so both
    // targets answer with the same one cycle latency
    always_ff @(posedge clock) begin
        if (sel && req.rden) begin
            rdata <= read_word;
        end
    end

    // io_in is sampled only at the read edge, any synchronising of outside
    // signals has to happen before they reach this block

endmodule

// ==== hw/read_response_mux.sv ====
// Read response mux
module read_response_mux
    import bus_map_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  bus_req_t              req,
    input  logic                  ram_hit,
    input  logic                  io_hit,
    input  logic [data_width-1:0] ram_rdata,
    input  logic [data_width-1:0] io_rdata,
    output bus_rsp_t              rsp
);

    // ------------------------------------------------------------
    // access classification
    // ------------------------------------------------------------

    // an access is live when either strobe is up
    logic access_active;

    // a live access that neither decoder claimed
    logic access_miss;

    assign access_active = req.wren | req.rden;
    assign access_miss   = access_active & ~ram_hit & ~io_hit;

    // ------------------------------------------------------------
    // response stage
    // ------------------------------------------------------------

    // which target answers the read that was made one cycle ago
    logic ram_sel_q;
    logic io_sel_q;

    // the previous access was a read, mapped or not
    logic read_q;

    // the previous access hit no target
    logic miss_q;

    // the selects only follow reads, so rdata stays zero after a write
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ram_sel_q <= 1'b0;
            io_sel_q  <= 1'b0;
            read_q    <= 1'b0;
            miss_q    <= 1'b0;
        end else begin
            ram_sel_q <= ram_hit & req.rden;
            io_sel_q  <= io_hit & req.rden;
            read_q    <= req.rden;
            miss_q    <= access_miss;
        end
    end

    // ------------------------------------------------------------
    // response drive
    // ------------------------------------------------------------

    // the targets already hold their read word, here we only pick one
    // an unmapped read falls through to zero with error set
    always_comb begin
        rsp.valid = read_q;
        rsp.error = miss_q;
        if (ram_sel_q) begin
            rsp.rdata = ram_rdata;
        end else if (io_sel_q) begin
            rsp.rdata = io_rdata;
        end else begin
            rsp.rdata = '0;
        end
    end

endmodule

// ==== hw/memory_map_top.sv ====
// Data memory map top level
module memory_map_top
    import bus_map_pkg::*;
(
    input  logic                                      clock,
    input  logic                                      rst_n,
    input  bus_req_t                                  req,
    input  logic [io_in_count-1:0][data_width-1:0]    io_in,
    output bus_rsp_t                                  rsp,
    output logic [io_out_count-1:0][data_width-1:0]   io_out
);

    // ------------------------------------------------------------
    // decode
    // ------------------------------------------------------------

    // the decoders only claim an address while a strobe is up
    logic req_active;
    logic ram_hit;
    logic io_hit;

    // registered read words held by each target
    logic [data_width-1:0] ram_rdata;
    logic [data_width-1:0] io_rdata;

    assign req_active = req.wren | req.rden;

    // RAM range, 768 words, not a power of two
    address_range_decoder_static #(
        .addr_base  (ram_base),
        .addr_bound (ram_bound)
    ) ram_decoder (
        .enable (req_active),
        .addr   (req.addr),
        .hit    (ram_hit)
    );

    // I/O range, eight words right above the RAM
    address_range_decoder_static #(
        .addr_base  (io_base),
        .addr_bound (io_bound)
    ) io_decoder (
        .enable (req_active),
        .addr   (req.addr),
        .hit    (io_hit)
    );

    // ------------------------------------------------------------
    // targets and response
    // ------------------------------------------------------------

    data_ram i_data_ram (
        .clock (clock),
        .sel   (ram_hit),
        .req   (req),
        .rdata (ram_rdata)
    );

    io_register_file i_io_register_file (
        .clock  (clock),
        .rst_n  (rst_n),
        .sel    (io_hit),
        .req    (req),
        .io_in  (io_in),
        .io_out (io_out),
        .rdata  (io_rdata)
    );

    // every access gets its response in the following cycle
    read_response_mux i_read_response_mux (
        .clock     (clock),
        .rst_n     (rst_n),
        .req       (req),
        .ram_hit   (ram_hit),
        .io_hit    (io_hit),
        .ram_rdata (ram_rdata),
        .io_rdata  (io_rdata),
        .rsp       (rsp)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
// Testbench clock source
module tb_clock_gen (
    output logic clock
);

    timeunit 1ns;
    timeprecision 100ps;

    // half of the 40 ns period
    localparam int half_period = 20;

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

endmodule

// ==== tests/memory_map_sva.sv ====
// Memory map bus assertions
module memory_map_sva
    import bus_map_pkg::*;
(
    input logic     clock,
    input logic     rst_n,
    input bus_req_t req,
    input bus_rsp_t rsp,
    input logic     ram_hit,
    input logic     io_hit
);

    timeunit 1ns;
    timeprecision 100ps;

    // a live access above the I/O block, where nothing is mapped
    logic unmapped;

    assign unmapped = (req.wren | req.rden) & (req.addr > addr_width'(io_bound));

    // write and read in one cycle have no defined meaning
    one_strobe: assert property (@(posedge clock) disable iff (!rst_n)
        !(req.wren && req.rden)) else $error("wren and rden high together");

    // valid is the read strobe delayed by exactly one cycle
    valid_after_read: assert property (@(posedge clock) disable iff (!rst_n)
        req.rden |=> rsp.valid) else $error("no valid after a read");
    valid_only_after_read: assert property (@(posedge clock) disable iff (!rst_n)
        !req.rden |=> !rsp.valid) else $error("valid without a read");

    // the RAM and I/O ranges do not overlap
    hits_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
        !(ram_hit && io_hit)) else $error("both decoders claimed one address");

    // error marks exactly the unmapped accesses
    error_after_miss: assert property (@(posedge clock) disable iff (!rst_n)
        unmapped |=> rsp.error) else $error("no error after an unmapped access");
    error_only_after_miss: assert property (@(posedge clock) disable iff (!rst_n)
        !unmapped |=> !rsp.error) else $error("error after a mapped or idle cycle");

endmodule

bind memory_map_top memory_map_sva i_memory_map_sva (
    .clock   (clock),
    .rst_n   (rst_n),
    .req     (req),
    .rsp     (rsp),
    .ram_hit (ram_hit),
    .io_hit  (io_hit)
);

// ==== tests/memory_map_tb.sv ====
// Memory map testbench
module memory_map_tb
    import bus_map_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_cycles   = 2000;
    localparam int random_count = 24;

    logic     clock;
    logic     rst_n;
    bus_req_t req;
    bus_rsp_t rsp;
    logic [io_in_count-1:0][data_width-1:0]  io_in;
    logic [io_out_count-1:0][data_width-1:0] io_out;

    // ------------------------------------------------------------
    // reference state
    // ------------------------------------------------------------

    // expected RAM contents, only read back after a write
    logic [data_width-1:0] ram_shadow [0:ram_depth-1];
    // expected io_out and the io_in value for the next cycle
    logic [io_out_count-1:0][data_width-1:0] io_model;
    logic [io_in_count-1:0][data_width-1:0]  io_in_next;
    // response owed by the access of the previous cycle
    bus_rsp_t    rsp_expected;
    logic [31:0] lcg_state;

    tb_clock_gen i_tb_clock_gen (
        .clock (clock)
    );

    memory_map_top i_memory_map_top (
        .clock  (clock),
        .rst_n  (rst_n),
        .req    (req),
        .io_in  (io_in),
        .rsp    (rsp),
        .io_out (io_out)
    );

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [data_width-1:0] exp,
                                   input logic [data_width-1:0] got);
        $display("ERR time %0t signal %s expected %h got %h", $time, name, exp, got);
        stop_with_failure();
    endtask

    task automatic check_rsp(input bus_rsp_t exp);
        if (rsp.valid !== exp.valid) begin
            report_mismatch("rsp.valid", data_width'(exp.valid), data_width'(rsp.valid));
        end
        if (rsp.error !== exp.error) begin
            report_mismatch("rsp.error", data_width'(exp.error), data_width'(rsp.error));
        end
        if (rsp.rdata !== exp.rdata) begin
            report_mismatch("rsp.rdata", exp.rdata, rsp.rdata);
        end
    endtask

    task automatic check_io(input int idx, input logic [data_width-1:0] exp);
        if (io_out[idx] !== exp) begin
            report_mismatch($sformatf("io_out[%0d]", idx), exp, io_out[idx]);
        end
    endtask

    // ------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic bus_req_t make_req(input logic wren, input logic rden,
                                          input logic [addr_width-1:0] addr,
                                          input logic [data_width-1:0] wdata);
        bus_req_t r;
        r.wren  = wren;
        r.rden  = rden;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    // anything above the I/O block is unmapped, reads of it return zero
    function automatic bus_rsp_t expected_rsp(input bus_req_t r,
                                              input logic [data_width-1:0] read_value);
        bus_rsp_t e;
        logic     miss;
        miss    = (r.wren || r.rden) && (r.addr > addr_width'(io_bound));
        e.valid = r.rden;
        e.error = miss;
        e.rdata = (r.rden && !miss) ? read_value : '0;
        return e;
    endfunction

    // one bus cycle, the access goes out and the response of the one
    // before it is checked half a cycle later, where rsp is settled
    task automatic run_cycle(input bus_req_t r, input logic [data_width-1:0] read_value);
        int slot;
        @(posedge clock);
        req   <= r;
        io_in <= io_in_next;
        @(negedge clock);
        check_rsp(rsp_expected);
        for (int k = 0; k < io_out_count; k++) begin
            check_io(k, io_model[k]);
        end
        rsp_expected = expected_rsp(r, read_value);
        slot = int'(r.addr) - io_base;
        if (r.wren && slot >= 0 && slot < io_out_count) begin
            io_model[slot] = r.wdata;
        end
        if (r.wren && r.addr <= addr_width'(ram_bound)) begin
            ram_shadow[int'(r.addr)] = r.wdata;
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        int                    fd;
        int                    n;
        int                    slot;
        int                    addr_list [random_count];
        string                 line;
        byte                   op;
        logic [31:0]           addr;
        logic [31:0]           data;
        logic [data_width-1:0] io_expected;
        req          = '0;
        io_in        = '0;
        io_in_next   = '0;
        io_model     = '0;
        rsp_expected = '0;
        lcg_state    = 32'd96;
        rst_n        = 1'b0;
        for (int c = 0; c < 3; c++) begin
            @(posedge clock);
        end
        rst_n <= 1'b1;
        // first cycle out of reset checks a quiet rsp and cleared io_out
        run_cycle(make_req(1'b0, 1'b0, '0, '0), '0);
        fd = $fopen("tests/memory_map_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/memory_map_cases.txt");
            stop_with_failure();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %h", op, addr, data);
            if (n != 3) begin
                $display("cases file line cannot be parsed: %s", line);
                stop_with_failure();
            end
            case (op)
                "W": run_cycle(make_req(1'b1, 1'b0, addr[addr_width-1:0],
                                        data[data_width-1:0]), '0);
                "R": run_cycle(make_req(1'b0, 1'b1, addr[addr_width-1:0], '0),
                               data[data_width-1:0]);
                "I": begin
                    io_in_next[addr[0]] = data[data_width-1:0];
                    run_cycle(make_req(1'b0, 1'b0, '0, '0), '0);
                end
                default: begin
                    $display("unknown operation in cases file: %s", line);
                    stop_with_failure();
                end
            endcase
        end
        $fclose(fd);
        // random pass fills RAM words, then reads alternate RAM and I/O
        for (int i = 0; i < random_count; i++) begin
            lcg_state    = lcg_next(lcg_state);
            addr_list[i] = int'((lcg_state >> 8) % 32'(ram_depth));
            lcg_state    = lcg_next(lcg_state);
            run_cycle(make_req(1'b1, 1'b0, addr_width'(addr_list[i]), lcg_state[31:16]), '0);
        end
        for (int i = 0; i < random_count; i++) begin
            run_cycle(make_req(1'b0, 1'b1, addr_width'(addr_list[i]), '0),
                      ram_shadow[addr_list[i]]);
            slot = i % 8;
            if (slot < io_out_count) begin
                io_expected = io_model[slot];
            end else begin
                io_expected = io_in_next[slot - io_out_count];
            end
            run_cycle(make_req(1'b0, 1'b1, addr_width'(io_base + slot), '0), io_expected);
        end
        // one idle cycle collects the last response
        run_cycle(make_req(1'b0, 1'b0, '0, '0), '0);
        $display("All tests passed");
        $finish;
    end

    // watchdog on the whole run
    initial begin
        for (int c = 0; c < max_cycles; c++) begin
            @(posedge clock);
        end
        $display("timeout, the run did not finish within %0d cycles", max_cycles);
        stop_with_failure();
    end

endmodule

// ==== tests/memory_map_cases.txt ====
# columns: op addr data, addr and data in hex
# W writes data, R reads and expects data, I sets io_in word addr to data
W 000 1234
W 2ff beef
R 000 1234
R 2ff beef
W 300 0a0a
W 301 1b1b
W 302 2c2c
W 303 3d3d
W 304 4e4e
W 305 5a5a
R 300 0a0a
R 305 5a5a
R 302 2c2c
I 000 c0de
I 001 f00d
R 306 c0de
R 307 f00d
W 306 ffff
W 307 eeee
R 306 c0de
R 307 f00d
W 010 7777
W 308 1111
W 3ff 2222
R 308 0000
R 3ff 0000
R 010 7777
R 000 1234
R 300 0a0a
R 2ff beef
R 305 5a5a
R 307 f00d

// ==== flist.f ====
hw/bus_map_pkg.sv
hw/address_range_decoder_static.sv
hw/data_ram.sv
hw/io_register_file.sv
hw/read_response_mux.sv
hw/memory_map_top.sv
tests/tb_clock_gen.sv
tests/memory_map_sva.sv
tests/memory_map_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the memory map testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module memory_map_tb -f flist.f -o memory_map_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/memory_map_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
fi

if grep -q "^All tests passed$" sim.log; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1
